// ==== design/board_pkg.sv ====
package board_pkg;

    // Grid geometry
    localparam int GRID_SIZE   = 28;   // Cells per side
    localparam int CELL_PIXELS = 4;    // Screen pixels per cell side
    localparam int GRID_X0     = 10;
    localparam int GRID_Y0     = 10;
    localparam int CELL_COUNT  = GRID_SIZE * GRID_SIZE;

    // Frame buffer size
    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    // Cursor start and clear position
    localparam int CURSOR_HOME = 14;

    // 3-bit RGB pixel colours
    localparam logic [2:0] COLOUR_EMPTY          = 3'b111;  // White
    localparam logic [2:0] COLOUR_PAINTED        = 3'b000;  // Black
    localparam logic [2:0] COLOUR_CURSOR_EMPTY   = 3'b100;  // Red
    localparam logic [2:0] COLOUR_CURSOR_PAINTED = 3'b001;  // Blue

    // Row times GRID_SIZE plus column
    typedef logic [9:0] cell_addr_t;

    // Grid coordinate, 0 to 27
    typedef logic [4:0] coord_t;

endpackage

// ==== design/paint_if.sv ====
`timescale 1ns/1ps

interface paint_if;
    import board_pkg::*;

    coord_t cursor_x;
    coord_t cursor_y;
    logic   paint;   // Set the cell under the cursor
    logic   clear;   // Level, empties the whole board

    modport source (output cursor_x, output cursor_y, output paint, output clear);

    modport store (input cursor_x, input cursor_y, input paint, input clear);

    // Display side only needs the position
    modport view (input cursor_x, input cursor_y);

endinterface

// ==== design/cursor_control.sv ====
`timescale 1ns/1ps

module cursor_control #(
    parameter int unsigned move_hold = 100000
) (
    input  logic       CLOCK_50,
    input  logic       rst_n,
    input  logic [3:0] key,       // Active low
    input  logic [9:0] sw,
    paint_if.source    pif
);
    import board_pkg::*;

    logic [3:0]  key_prev;
    logic [3:0]  press;
    logic [31:0] hold_cnt;
    logic        ready;
    logic        move_ok;
    coord_t      next_x;
    coord_t      next_y;

    // Falling edge on an active-low key
    assign press = ~key & key_prev;

    assign ready   = (hold_cnt == 32'd0) && sw[9];
    assign move_ok = ready && (|press);

    // Painting uses the position held before any move this cycle
    assign pif.paint = ready && sw[1] && !pif.clear;

    // All pressed keys apply, each clamped at the grid edge
    always_comb begin
        next_x = pif.cursor_x;
        next_y = pif.cursor_y;
        if (press[3] && next_x < coord_t'(GRID_SIZE - 1)) begin
            next_x = next_x + 5'd1;   // Right
        end
        if (press[2] && next_x > 5'd0) begin
            next_x = next_x - 5'd1;   // Left
        end
        if (press[1] && next_y > 5'd0) begin
            next_y = next_y - 5'd1;   // Up
        end
        if (press[0] && next_y < coord_t'(GRID_SIZE - 1)) begin
            next_y = next_y + 5'd1;   // Down
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            key_prev     <= 4'hf;
            hold_cnt     <= 32'd0;
            pif.cursor_x <= coord_t'(CURSOR_HOME);
            pif.cursor_y <= coord_t'(CURSOR_HOME);
            pif.clear    <= 1'b0;
        end else begin
            key_prev  <= key;
            pif.clear <= ~sw[9];
            if (!sw[9]) begin
                // Board clear sends the cursor home
                pif.cursor_x <= coord_t'(CURSOR_HOME);
                pif.cursor_y <= coord_t'(CURSOR_HOME);
                hold_cnt     <= 32'd0;
            end else if (move_ok) begin
                pif.cursor_x <= next_x;
                pif.cursor_y <= next_y;
                hold_cnt     <= move_hold;
            end else if (hold_cnt != 32'd0) begin
                hold_cnt <= hold_cnt - 32'd1;   // Presses dropped meanwhile
            end
        end
    end

    a_cursor_in_grid : assert property (
        @(posedge CLOCK_50) disable iff (!rst_n)
        (pif.cursor_x < coord_t'(GRID_SIZE)) && (pif.cursor_y < coord_t'(GRID_SIZE))
    ) else $error("cursor outside the grid");

    // Store must never see a write during a clear
    a_no_paint_in_clear : assert property (
        @(posedge CLOCK_50) disable iff (!rst_n)
        !(pif.paint && pif.clear)
    ) else $error("paint asserted while clear is high");

endmodule

// ==== design/cell_store.sv ====
`timescale 1ns/1ps

module cell_store (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    paint_if.store              pif,
    input  board_pkg::cell_addr_t rd_addr,
    output logic                rd_cell
);
    import board_pkg::*;

    logic [CELL_COUNT-1:0] cells;   // One bit per grid cell, set means painted
    cell_addr_t            wr_addr;

    assign wr_addr = cell_addr_t'(pif.cursor_y) * cell_addr_t'(GRID_SIZE)
                   + cell_addr_t'(pif.cursor_x);

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n || pif.clear) begin
            cells <= '0;
        end else if (pif.paint) begin
            cells[wr_addr] <= 1'b1;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge CLOCK_50) begin
        if (rd_addr < cell_addr_t'(CELL_COUNT)) begin
            rd_cell <= cells[rd_addr];
        end else begin
            rd_cell <= 1'b0;
        end
    end

    // Renderer reads every cycle and parks on cell 0 outside the grid
    a_rd_addr_range : assert property (
        @(posedge CLOCK_50) disable iff (!rst_n)
        rd_addr < cell_addr_t'(CELL_COUNT)
    ) else $error("read address beyond the cell array");

endmodule

// ==== design/grid_renderer.sv ====
`timescale 1ns/1ps

module grid_renderer (
    input  logic                  CLOCK_50,
    input  logic                  rst_n,
    paint_if.view                 pif,
    output board_pkg::cell_addr_t rd_addr,
    input  logic                  rd_cell,
    output logic [7:0]            pix_x,
    output logic [6:0]            pix_y,
    output logic [2:0]            colour,
    output logic                  plot
);
    import board_pkg::*;

    logic [7:0] scan_x;
    logic [6:0] scan_y;
    logic [7:0] off_x;
    logic [6:0] off_y;
    coord_t     col;
    coord_t     row;
    logic       in_grid;
    logic       on_cursor;

    // Stage one registers
    logic [7:0] s1_x;
    logic [6:0] s1_y;
    logic       s1_in_grid;
    logic       s1_cursor;
    logic       s1_valid;
    logic [2:0] next_colour;

    // Free-running raster, no gap between frames
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            scan_x <= 8'd0;
            scan_y <= 7'd0;
        end else if (scan_x == 8'(SCREEN_W - 1)) begin
            scan_x <= 8'd0;
            if (scan_y == 7'(SCREEN_H - 1)) begin
                scan_y <= 7'd0;
            end else begin
                scan_y <= scan_y + 7'd1;
            end
        end else begin
            scan_x <= scan_x + 8'd1;
        end
    end

    // Grid spans 10 up to but excluding 122 on both axes
    assign in_grid = (scan_x >= 8'(GRID_X0))
                  && (scan_x <  8'(GRID_X0 + GRID_SIZE * CELL_PIXELS))
                  && (scan_y >= 7'(GRID_Y0))
                  && (scan_y <  7'(GRID_Y0 + GRID_SIZE * CELL_PIXELS));

    assign off_x = scan_x - 8'(GRID_X0);
    assign off_y = scan_y - 7'(GRID_Y0);
    assign col   = coord_t'(off_x / 8'(CELL_PIXELS));
    assign row   = coord_t'(off_y / 7'(CELL_PIXELS));

    assign on_cursor = (col == pif.cursor_x) && (row == pif.cursor_y);

    assign rd_addr = in_grid ? cell_addr_t'(row) * cell_addr_t'(GRID_SIZE) + cell_addr_t'(col)
                             : '0;

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        s1_x       <= scan_x;
        s1_y       <= scan_y;
        s1_in_grid <= in_grid;
        s1_cursor  <= in_grid && on_cursor;
    end

    // rd_cell lines up with stage one here
    always_comb begin
        if (!s1_in_grid) begin
            next_colour = COLOUR_EMPTY;
        end else if (s1_cursor) begin
            next_colour = rd_cell ? COLOUR_CURSOR_PAINTED : COLOUR_CURSOR_EMPTY;
        end else begin
            next_colour = rd_cell ? COLOUR_PAINTED : COLOUR_EMPTY;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            plot <= 1'b0;
        end else begin
            plot <= s1_valid;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        pix_x  <= s1_x;
        pix_y  <= s1_y;
        colour <= next_colour;
    end

endmodule

// ==== design/cursor_readout.sv ====
`timescale 1ns/1ps

module cursor_readout (
    paint_if.view      pif,
    output logic [6:0] hex3,
    output logic [6:0] hex2,
    output logic [6:0] hex1,
    output logic [6:0] hex0
);
    import board_pkg::*;

    logic [7:0] x_bcd;   // Tens in the upper nibble
    logic [7:0] y_bcd;

    // Coordinate never exceeds 27, so two subtractions suffice
    function automatic logic [7:0] to_bcd(input coord_t v);
        logic [3:0] tens;
        logic [4:0] rest;
        tens = 4'd0;
        rest = v;
        if (rest >= 5'd20) begin
            tens = 4'd2;
            rest = rest - 5'd20;
        end else if (rest >= 5'd10) begin
            tens = 4'd1;
            rest = rest - 5'd10;
        end
        return {tens, rest[3:0]};
    endfunction

    // Segments gfedcba, low lights the segment
    function automatic logic [6:0] seg7(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;   // Blank
        endcase
    endfunction

    assign x_bcd = to_bcd(pif.cursor_x);
    assign y_bcd = to_bcd(pif.cursor_y);

    assign hex3 = seg7(x_bcd[7:4]);
    assign hex2 = seg7(x_bcd[3:0]);
    assign hex1 = seg7(y_bcd[7:4]);
    assign hex0 = seg7(y_bcd[3:0]);

endmodule

// ==== design/drawing_board.sv ====
`timescale 1ns/1ps

module drawing_board #(
    parameter int unsigned move_hold = 100000   // Cycles of key lockout after a move
) (
    input  logic       CLOCK_50,
    input  logic       rst_n,
    input  logic [9:0] sw,
    input  logic [3:0] key,
    output logic [7:0] pix_x,
    output logic [6:0] pix_y,
    output logic [2:0] colour,
    output logic       plot,
    output logic [6:0] hex3,
    output logic [6:0] hex2,
    output logic [6:0] hex1,
    output logic [6:0] hex0
);
    import board_pkg::*;

    cell_addr_t rd_addr;
    logic       rd_cell;

    paint_if pif ();

    cursor_control #(
        .move_hold (move_hold)
    ) u_cursor_control (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .key      (key),
        .sw       (sw),
        .pif      (pif.source)
    );

    cell_store u_cell_store (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .pif      (pif.store),
        .rd_addr  (rd_addr),
        .rd_cell  (rd_cell)
    );

    grid_renderer u_grid_renderer (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .pif      (pif.view),
        .rd_addr  (rd_addr),
        .rd_cell  (rd_cell),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .colour   (colour),
        .plot     (plot)
    );

    cursor_readout u_cursor_readout (
        .pif  (pif.view),
        .hex3 (hex3),
        .hex2 (hex2),
        .hex1 (hex1),
        .hex0 (hex0)
    );

endmodule

// ==== bench/tb_drawing_board.sv ====
`timescale 1ns/1ps

module tb_drawing_board;

    localparam int MOVE_HOLD    = 8;
    localparam int SEED         = 90;
    localparam int GRID         = 28;
    localparam int HOME         = 14;
    localparam int FRAME_PIXELS = 160 * 120;
    localparam int WALK_MOVES   = 30;
    // Five frame checks of up to two frames each, stimulus, wide margin
    localparam int TIMEOUT_CYCLES = 400000;

    localparam logic [2:0] WHITE = 3'b111;
    localparam logic [2:0] BLACK = 3'b000;
    localparam logic [2:0] RED   = 3'b100;
    localparam logic [2:0] BLUE  = 3'b001;

    logic       CLOCK_50;
    logic       rst_n;
    logic [9:0] sw;
    logic [3:0] key;
    logic [7:0] pix_x;
    logic [6:0] pix_y;
    logic [2:0] colour;
    logic       plot;
    logic [6:0] hex3;
    logic [6:0] hex2;
    logic [6:0] hex1;
    logic [6:0] hex0;

    // Reference model state
    int         m_cx;
    int         m_cy;
    int         m_hold;
    int         m_lost;        // Presses dropped inside the hold window
    bit         m_clear;
    logic [3:0] m_key_prev;
    bit         m_cells [0:GRID*GRID-1];
    logic [9:0] sw_val;

    int errors;
    int cycles;
    bit frame_req;
    bit frame_done;

    drawing_board #(
        .move_hold (MOVE_HOLD)
    ) DUT (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .sw       (sw),
        .key      (key),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .colour   (colour),
        .plot     (plot),
        .hex3     (hex3),
        .hex2     (hex2),
        .hex1     (hex1),
        .hex0     (hex0)
    );

    always #20 CLOCK_50 = ~CLOCK_50;

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // Active-low gfedcba patterns
    function automatic logic [6:0] segments(input int digit);
        case (digit)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            7:       return 7'b1111000;
            8:       return 7'b0000000;
            default: return 7'b0010000;
        endcase
    endfunction

    function automatic logic [2:0] exp_colour(input int x, input int y);
        int col;
        int row;
        bit painted;
        if (x < 10 || x >= 10 + GRID * 4 || y < 10 || y >= 10 + GRID * 4) begin
            return WHITE;
        end
        col     = (x - 10) / 4;
        row     = (y - 10) / 4;
        painted = m_cells[row * GRID + col];
        if (col == m_cx && row == m_cy) begin
            return painted ? BLUE : RED;
        end
        return painted ? BLACK : WHITE;
    endfunction

    // Applies the board rules for the edge that samples k and s
    task automatic model_edge(input logic [3:0] k, input logic [9:0] s);
        logic [3:0] press;
        bit         ready;
        int         i;
        press = ~k & m_key_prev;
        ready = (m_hold == 0) && s[9];
        if (m_clear) begin
            for (i = 0; i < GRID * GRID; i++) begin
                m_cells[i] = 1'b0;
            end
        end else if (ready && s[1]) begin
            m_cells[m_cy * GRID + m_cx] = 1'b1;   // Position before the move
        end
        if (!s[9]) begin
            m_cx   = HOME;
            m_cy   = HOME;
            m_hold = 0;
        end else if (ready && press != 4'b0000) begin
            if (press[3] && m_cx < GRID - 1) m_cx++;
            if (press[2] && m_cx > 0) m_cx--;
            if (press[1] && m_cy > 0) m_cy--;
            if (press[0] && m_cy < GRID - 1) m_cy++;
            m_hold = MOVE_HOLD;
        end else if (m_hold != 0) begin
            if (press != 4'b0000) m_lost++;
            m_hold--;
        end
        m_clear    = !s[9];
        m_key_prev = k;
    endtask

    task automatic step(input logic [3:0] k);
        @(posedge CLOCK_50);
        #2;
        key = k;
        sw  = sw_val;
        model_edge(k, sw_val);
    endtask

    task automatic settle();
        repeat (MOVE_HOLD + 4) step(4'hf);
    endtask

    // Hold the keys in mask down for some cycles, then release
    task automatic press_keys(input logic [3:0] mask, input int held);
        repeat (held) step(~mask);
        settle();
    endtask

    task automatic check_hex();
        check_value("hex3", int'(segments(m_cx / 10)), int'(hex3));
        check_value("hex2", int'(segments(m_cx % 10)), int'(hex2));
        check_value("hex1", int'(segments(m_cy / 10)), int'(hex1));
        check_value("hex0", int'(segments(m_cy % 10)), int'(hex0));
    endtask

    // Keep the model ticking while the compare process checks a frame
    task automatic check_frame();
        frame_req = 1'b1;
        while (!frame_done) step(4'hf);
        frame_req = 1'b0;
        while (frame_done) step(4'hf);
    endtask

    always begin : frame_compare
        int n;
        int ex;
        int ey;
        wait (frame_req);
        @(negedge CLOCK_50);
        while (!(plot && pix_x == 8'd0 && pix_y == 7'd0)) @(negedge CLOCK_50);
        for (n = 0; n < FRAME_PIXELS; n++) begin
            ex = n % 160;
            ey = n / 160;
            check_value("plot", 1, int'(plot));
            check_value("pix_x", ex, int'(pix_x));
            check_value("pix_y", ey, int'(pix_y));
            check_value("colour", int'(exp_colour(ex, ey)), int'(colour));
            @(negedge CLOCK_50);
        end
        frame_done = 1'b1;
        wait (!frame_req);
        frame_done = 1'b0;
    end

    always @(posedge CLOCK_50) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [3:0] mask;
        int         i;
        CLOCK_50   = 1'b0;
        rst_n      = 1'b0;
        key        = 4'hf;
        sw_val     = 10'h200;   // Switch 9 high, no clear
        sw         = sw_val;
        errors     = 0;
        cycles     = 0;
        frame_req  = 1'b0;
        frame_done = 1'b0;
        m_cx       = HOME;
        m_cy       = HOME;
        m_hold     = 0;
        m_lost     = 0;
        m_clear    = 1'b0;
        m_key_prev = 4'hf;
        for (i = 0; i < GRID * GRID; i++) begin
            m_cells[i] = 1'b0;
        end
        void'($urandom(SEED));

        repeat (16) @(posedge CLOCK_50);
        #2 rst_n = 1'b1;

        // Home position after reset
        settle();
        check_hex();
        check_frame();

        // Single moves, then one long press
        press_keys(4'b1000, 1);
        check_hex();
        press_keys(4'b0100, 1);
        check_hex();
        press_keys(4'b0010, 1);
        check_hex();
        press_keys(4'b0001, 1);
        check_hex();
        press_keys(4'b1000, 3 * MOVE_HOLD);
        check_hex();

        // Bottom-right corner, row 27 is cut at line 119
        repeat (16) press_keys(4'b1000, 1);
        repeat (16) press_keys(4'b0001, 1);
        check_hex();
        check_frame();
        repeat (30) press_keys(4'b0100, 1);
        repeat (30) press_keys(4'b0010, 1);
        check_hex();

        // Random painting walk
        repeat (8) press_keys(4'b1000, 1);
        repeat (8) press_keys(4'b0001, 1);
        sw_val[1] = 1'b1;
        settle();
        repeat (WALK_MOVES) begin
            mask = 4'b0001 << ($urandom % 4);
            press_keys(mask, 1);
        end
        check_hex();
        check_frame();

        // Presses inside the hold window
        step(4'b0111);
        step(4'hf);
        step(4'b1110);
        repeat (5) step(4'hf);
        step(4'b1011);
        settle();
        check_hex();
        if (m_lost == 0) begin
            errors++;
            $display("The hold test sent no press inside the hold window");
        end
        check_frame();

        // Board clear
        sw_val[1] = 1'b0;
        settle();
        sw_val[9] = 1'b0;
        repeat (4) step(4'hf);
        sw_val[9] = 1'b1;
        settle();
        check_hex();
        check_frame();

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
design/board_pkg.sv
design/paint_if.sv
design/cursor_control.sv
design/cell_store.sv
design/grid_renderer.sv
design/cursor_readout.sv
design/drawing_board.sv
bench/tb_drawing_board.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_drawing_board -f flist.f -o sim_drawing_board

out=$(./obj_dir/sim_drawing_board)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
